/* hdl/mac_pkg.sv */
//****************************************
// Shared widths and CPU data word type for the MAC address adder
// Widths are architectural and fixed at 16-bit words
// group_width must divide word_width evenly
//****************************************

`default_nettype none

package mac_pkg;

  localparam int word_width  = 16; // Data and address width
  localparam int byte_width  = 8;  // Short displacement width
  localparam int group_width = 4;  // Carry lookahead group size

  // CPU data word, seen either whole or as two bytes
  typedef union packed {
    logic [word_width-1:0] word;
    struct packed {
      logic [word_width-byte_width-1:0] hi;
      logic [byte_width-1:0]            lo;
    } half;
  } cd_word_u;

endpackage : mac_pkg

`default_nettype wire

/* hdl/mac_reg_if.sv */
//****************************************
// Base register sources and select strobes
// Strobes are levels that act in the same cycle
// No handshake, several strobes may be high at once
//****************************************

`default_nettype none
`timescale 1ns/1ps

interface mac_reg_if
  import mac_pkg::*;
();

  logic [word_width-1:0] br;  // B register
  logic [word_width-1:0] rb;  // Microcode register B
  logic [word_width-1:0] xr;  // X register
  logic [word_width-1:0] lca; // Load control address

  logic pb;   // Select br
  logic prb;  // Select rb
  logic px;   // Select xr
  logic plca; // Select lca

  modport source (
    output br, rb, xr, lca,
    output pb, prb, px, plca
  );

  modport sink (
    input br, rb, xr, lca,
    input pb, prb, px, plca
  );

endinterface : mac_reg_if

`default_nettype wire

/* hdl/mac_base_select.sv */
//****************************************
// Base term gating for the address adder
// Selected sources combine by bitwise OR
// Base is zero when no strobe is high
//****************************************

`default_nettype none
`timescale 1ns/1ps

module mac_base_select
  import mac_pkg::*;
(
  mac_reg_if.sink               regs,
  output logic [word_width-1:0] base
);

  logic [word_width-1:0] br_gated;
  logic [word_width-1:0] rb_gated;
  logic [word_width-1:0] xr_gated;
  logic [word_width-1:0] lca_gated;

  // Each source masked by its own strobe
  assign br_gated  = regs.br  & {word_width{regs.pb}};
  assign rb_gated  = regs.rb  & {word_width{regs.prb}};
  assign xr_gated  = regs.xr  & {word_width{regs.px}};
  assign lca_gated = regs.lca & {word_width{regs.plca}};

  // Wired OR of the gated sources
  assign base = br_gated | rb_gated | xr_gated | lca_gated;

endmodule : mac_base_select

`default_nettype wire

/* hdl/mac_disp_extend.sv */
//****************************************
// Displacement term for the address adder
// cds low gives the full CPU data word
// cds high gives the low byte sign-extended
//****************************************

`default_nettype none
`timescale 1ns/1ps

module mac_disp_extend
  import mac_pkg::*;
(
  input  cd_word_u              cd,
  input  logic                  cds,
  output logic [word_width-1:0] disp
);

  logic                  sign_bit;
  logic [word_width-1:0] short_disp;

  assign sign_bit = cd.half.lo[byte_width-1];

  // High byte replaced by copies of the sign bit
  assign short_disp = {{(word_width-byte_width){sign_bit}}, cd.half.lo};

  always_comb begin
    if (cds) begin
      disp = short_disp;  // -128 .. +127
    end else begin
      disp = cd.word;
    end
  end

endmodule : mac_disp_extend

`default_nettype wire

/* hdl/mac_fast_add.sv */
//****************************************
// Carry lookahead adder, 16 bits in 4-bit groups
// Sum wraps modulo 2^16
// No carry out, the final carry is dropped
//****************************************

`default_nettype none
`timescale 1ns/1ps

module mac_fast_add
  import mac_pkg::*;
(
  input  logic [word_width-1:0] base,
  input  logic [word_width-1:0] disp,
  output logic [word_width-1:0] sum
);

  logic [word_width-1:0]             bit_g;   // Bit generate
  logic [word_width-1:0]             bit_p;   // Bit propagate
  logic [word_width/group_width-1:0] grp_g;   // Group generate
  logic [word_width/group_width-1:0] grp_p;   // Group propagate
  logic [word_width/group_width-1:0] grp_cin; // Carry into each group
  logic [word_width-1:0]             carry;   // Carry into each bit

  assign bit_g = base & disp;
  assign bit_p = base ^ disp;

  // Group generate and propagate
  always_comb begin
    for (int k = 0; k < word_width/group_width; k++) begin
      grp_g[k] = 1'b0;
      grp_p[k] = 1'b1;
      for (int i = 0; i < group_width; i++) begin
        grp_g[k] = bit_g[k*group_width+i] | (bit_p[k*group_width+i] & grp_g[k]);
        grp_p[k] = grp_p[k] & bit_p[k*group_width+i];
      end
    end
  end

  // Two-level lookahead, each group carry as a sum of products
  always_comb begin
    logic term;
    for (int k = 0; k < word_width/group_width; k++) begin
      grp_cin[k] = 1'b0; // Group 0 has no carry in
      for (int j = 0; j < k; j++) begin
        term = grp_g[j];
        for (int m = j + 1; m < k; m++) begin
          term = term & grp_p[m];
        end
        grp_cin[k] = grp_cin[k] | term;
      end
    end
  end

  // Carries inside each group start from the lookahead carry
  always_comb begin
    for (int k = 0; k < word_width/group_width; k++) begin
      carry[k*group_width] = grp_cin[k];
      for (int i = 1; i < group_width; i++) begin
        carry[k*group_width+i] = bit_g[k*group_width+i-1]
                               | (bit_p[k*group_width+i-1] & carry[k*group_width+i-1]);
      end
    end
  end

  assign sum = bit_p ^ carry;

endmodule : mac_fast_add

`default_nettype wire

/* hdl/mac_add.sv */
//****************************************
// MAC address adder, base plus displacement
// Purely combinational, no carry out
// cd is always added, whatever the strobes
//****************************************

`default_nettype none
`timescale 1ns/1ps

module mac_add
  import mac_pkg::*;
(
  mac_reg_if.sink               regs,
  input  cd_word_u              cd,
  input  logic                  cds,
  output logic [word_width-1:0] sum
);

  logic [word_width-1:0] base; // Gated register term
  logic [word_width-1:0] disp; // CPU data term

  mac_base_select u_base_select (
    .regs (regs),
    .base (base)
  );

  mac_disp_extend u_disp_extend (
    .cd   (cd),
    .cds  (cds),
    .disp (disp)
  );

  // Fast adder combines both terms
  mac_fast_add u_fast_add (
    .base (base),
    .disp (disp),
    .sum  (sum)
  );

endmodule : mac_add

`default_nettype wire

/* hdl/mac_top.sv */
//****************************************
// MAC top level with memory address register
// address follows the sum one cycle after load
// Synchronous active-high reset clears address
// No handshake, a load may come every cycle
//****************************************

`default_nettype none
`timescale 1ns/1ps

module mac_top
  import mac_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic [word_width-1:0] br,      // B register
  input  logic [word_width-1:0] rb,      // Microcode register B
  input  logic [word_width-1:0] xr,      // X register
  input  logic [word_width-1:0] lca,     // Load control address
  input  logic                  pb,
  input  logic                  prb,
  input  logic                  px,
  input  logic                  plca,
  input  logic [word_width-1:0] cd,      // CPU data
  input  logic                  cds,     // Short displacement select
  input  logic                  load,    // Capture the sum
  output logic [word_width-1:0] address
);

  cd_word_u              cd_word;
  logic [word_width-1:0] sum;

  mac_reg_if u_regs ();

  // Register sources onto the interface
  assign u_regs.br   = br;
  assign u_regs.rb   = rb;
  assign u_regs.xr   = xr;
  assign u_regs.lca  = lca;
  assign u_regs.pb   = pb;
  assign u_regs.prb  = prb;
  assign u_regs.px   = px;
  assign u_regs.plca = plca;

  assign cd_word.word = cd;

  mac_add u_add (
    .regs (u_regs.sink),
    .cd   (cd_word),
    .cds  (cds),
    .sum  (sum)
  );

  // Memory address register
  always_ff @(posedge clk) begin
    if (reset) begin
      address <= '0;
    end else if (load) begin
      address <= sum;
    end
  end

endmodule : mac_top

`default_nettype wire

/* dv/mac_tb.sv */
//****************************************
// Self-checking testbench for mac_top
// Table rows carry stimulus and the expected address
// Random rows follow and are checked against a reference model
// Inputs change 1 ns after each rising edge, address sampled there too
// LFSR seed fixed at 80, one step per bit drawn
//****************************************

`default_nettype none
`timescale 1ns/1ps

module mac_tb
  import mac_pkg::*;
();

  localparam int clk_period      = 8;
  localparam int reset_cycles    = 16;
  localparam int num_fixed_rows  = 20;
  localparam int num_carry_rows  = word_width / group_width;
  localparam int num_table_rows  = num_fixed_rows + num_carry_rows;
  localparam int num_random_rows = 64;
  localparam int watchdog_ns     = (num_table_rows + num_random_rows + 20) * clk_period;

  // One stimulus row
  typedef struct packed {
    logic [word_width-1:0] br;
    logic [word_width-1:0] rb;
    logic [word_width-1:0] xr;
    logic [word_width-1:0] lca;
    logic [3:0]            sel;  // pb, prb, px, plca
    logic [word_width-1:0] cd;
    logic                  cds;
    logic                  load;
    logic [word_width-1:0] exp;  // Address after the next edge
  } row_t;

  logic                  clk;
  logic                  reset;
  logic [word_width-1:0] br;
  logic [word_width-1:0] rb;
  logic [word_width-1:0] xr;
  logic [word_width-1:0] lca;
  logic                  pb;
  logic                  prb;
  logic                  px;
  logic                  plca;
  logic [word_width-1:0] cd;
  logic                  cds;
  logic                  load;
  logic [word_width-1:0] address;

  row_t                  table_rows [num_table_rows];
  logic [15:0]           lfsr_state;
  logic [word_width-1:0] expected;   // Model of the address register
  string                 last_row;   // Row whose result is checked next

  mac_top u_dut (
    .clk     (clk),
    .reset   (reset),
    .br      (br),
    .rb      (rb),
    .xr      (xr),
    .lca     (lca),
    .pb      (pb),
    .prb     (prb),
    .px      (px),
    .plca    (plca),
    .cd      (cd),
    .cds     (cds),
    .load    (load),
    .address (address)
  );

  always #(clk_period/2) clk = ~clk;

  // Galois LFSR, taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 16'hB400;
    end
    return next;
  endfunction

  function automatic logic [15:0] draw_bits(input int count);
    logic [15:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[14:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // Reference sum from the address rules
  function automatic logic [word_width-1:0] model_sum(input row_t row);
    logic [word_width-1:0] base;
    logic [word_width-1:0] disp;
    base = '0;
    if (row.sel[3]) begin
      base = base | row.br;
    end
    if (row.sel[2]) begin
      base = base | row.rb;
    end
    if (row.sel[1]) begin
      base = base | row.xr;
    end
    if (row.sel[0]) begin
      base = base | row.lca;
    end
    if (row.cds) begin
      disp = {{(word_width-byte_width){row.cd[byte_width-1]}}, row.cd[byte_width-1:0]};
    end else begin
      disp = row.cd;
    end
    return base + disp;
  endfunction

  function automatic row_t random_row(input logic [word_width-1:0] held);
    row_t        row;
    logic [15:0] bits;
    row.br   = draw_bits(16);
    row.rb   = draw_bits(16);
    row.xr   = draw_bits(16);
    row.lca  = draw_bits(16);
    bits     = draw_bits(4);
    row.sel  = bits[3:0];
    row.cd   = draw_bits(16);
    bits     = draw_bits(1);
    row.cds  = bits[0];
    bits     = draw_bits(1);
    row.load = bits[0];
    row.exp  = row.load ? model_sum(row) : held; // Old address kept without load
    return row;
  endfunction

  // Row with the default register values
  task automatic put_row(
    input int                    idx,
    input logic [3:0]            sel_val,
    input logic [word_width-1:0] cd_val,
    input logic                  cds_val,
    input logic                  load_val,
    input logic [word_width-1:0] exp_val
  );
    table_rows[idx].br   = 16'h1000;
    table_rows[idx].rb   = 16'h0200;
    table_rows[idx].xr   = 16'h0030;
    table_rows[idx].lca  = 16'h4004;
    table_rows[idx].sel  = sel_val;
    table_rows[idx].cd   = cd_val;
    table_rows[idx].cds  = cds_val;
    table_rows[idx].load = load_val;
    table_rows[idx].exp  = exp_val;
  endtask

  task automatic fill_table();
    int          width;
    logic [31:0] full;
    put_row(0,  4'b1000, 16'h0123, 1'b0, 1'b0, 16'h0000); // No load right after reset
    put_row(1,  4'b1000, 16'h0123, 1'b0, 1'b1, 16'h1123);
    put_row(2,  4'b0100, 16'h0123, 1'b0, 1'b1, 16'h0323);
    put_row(3,  4'b0010, 16'h0123, 1'b0, 1'b1, 16'h0153);
    put_row(4,  4'b0001, 16'h0123, 1'b0, 1'b1, 16'h4127);
    put_row(5,  4'b1000, 16'hAB7F, 1'b1, 1'b1, 16'h107F); // +127
    put_row(6,  4'b1000, 16'h127F, 1'b1, 1'b1, 16'h107F);
    put_row(7,  4'b1000, 16'h0080, 1'b1, 1'b1, 16'h0F80); // -128
    put_row(8,  4'b1000, 16'hFF80, 1'b1, 1'b1, 16'h0F80);
    put_row(9,  4'b0000, 16'h0080, 1'b1, 1'b1, 16'hFF80); // Displacement alone
    put_row(10, 4'b0000, 16'h5A5A, 1'b0, 1'b1, 16'h5A5A);
    put_row(11, 4'b1111, 16'h0000, 1'b0, 1'b1, 16'h5234); // All four ORed
    put_row(12, 4'b1010, 16'h0001, 1'b0, 1'b1, 16'h1031);
    put_row(13, 4'b1010, 16'h0000, 1'b0, 1'b1, 16'h0FF0);
    table_rows[13].br = 16'h00F0; // Overlapping bits, OR and not add
    table_rows[13].xr = 16'h0FF0;
    put_row(14, 4'b1000, 16'h00FF, 1'b1, 1'b1, 16'h7FFF);
    table_rows[14].br = 16'h8000;
    put_row(15, 4'b1000, 16'h00F1, 1'b0, 1'b1, 16'h1000);
    table_rows[15].br = 16'h0F0F;
    put_row(16, 4'b0100, 16'h0004, 1'b0, 1'b1, 16'h0204);
    put_row(17, 4'b1111, 16'hFFFF, 1'b1, 1'b0, 16'h0204); // Held
    put_row(18, 4'b0000, 16'h1234, 1'b0, 1'b0, 16'h0204);
    put_row(19, 4'b0001, 16'h0010, 1'b0, 1'b1, 16'h4014);
    // All ones plus one, one row per group boundary
    for (int k = 0; k < num_carry_rows; k++) begin
      width = (k + 1) * group_width;
      full  = 32'd1 << width;
      put_row(num_fixed_rows + k, 4'b1000, 16'h0001, 1'b0, 1'b1, full[15:0]);
      table_rows[num_fixed_rows + k].br = 16'hFFFF >> (word_width - width);
    end
  endtask

  task automatic check_address(input logic [word_width-1:0] exp_val, input string what);
    assert (address === exp_val) else begin
      $display("Fail at %0d ns: %s, address expected %h, got %h",
               $time, what, exp_val, address);
      $display("sim failed");
      $fatal(1, "Address mismatch");
    end
  endtask

  // Check the last row's result, then drive this one
  task automatic apply_row(input row_t row, input string what);
    @(posedge clk);
    #1;
    check_address(expected, last_row);
    br       = row.br;
    rb       = row.rb;
    xr       = row.xr;
    lca      = row.lca;
    pb       = row.sel[3];
    prb      = row.sel[2];
    px       = row.sel[1];
    plca     = row.sel[0];
    cd       = row.cd;
    cds      = row.cds;
    load     = row.load;
    last_row = what;
  endtask

  initial begin
    #(watchdog_ns);
    $display("sim failed");
    $fatal(1, "Watchdog timeout, the testbench did not finish in time");
  end

  initial begin
    row_t row;
    clk        = 1'b0;
    reset      = 1'b1;
    br         = '0;
    rb         = '0;
    xr         = '0;
    lca        = '0;
    pb         = 1'b0;
    prb        = 1'b0;
    px         = 1'b0;
    plca       = 1'b0;
    cd         = '0;
    cds        = 1'b0;
    load       = 1'b0;
    lfsr_state = 16'd80;
    expected   = '0;
    last_row   = "reset";
    fill_table();

    repeat (reset_cycles) begin
      @(posedge clk);
      #1;
      check_address('0, "during reset");
    end
    reset = 1'b0;

    for (int i = 0; i < num_table_rows; i++) begin
      apply_row(table_rows[i], $sformatf("table row %0d", i));
      expected = table_rows[i].exp;
    end

    for (int i = 0; i < num_random_rows; i++) begin
      row = random_row(expected);
      apply_row(row, $sformatf("random row %0d", i));
      expected = row.exp;
    end

    @(posedge clk);
    #1;
    check_address(expected, last_row);
    $display("sim passed");
    $finish;
  end

endmodule : mac_tb

`default_nettype wire

/* files.f */
hdl/mac_pkg.sv
hdl/mac_reg_if.sv
hdl/mac_base_select.sv
hdl/mac_disp_extend.sv
hdl/mac_fast_add.sv
hdl/mac_add.sv
hdl/mac_top.sv
dv/mac_tb.sv

/* Makefile */
# Verilator flow for the MAC address adder
# make lint, make sim, make clean

TOOL       := verilator
TOP        := mac_tb
RTL_TOP    := mac_top
FILE_LIST  := files.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

SOURCES    := $(shell cat $(FILE_LIST))
SIM_BIN    := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Exit status of the simulation binary is the pass or fail result
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
